// File: xfer_consts.svh
`ifndef XFER_CONSTS_SVH
`define XFER_CONSTS_SVH

// stream and datapath sizing
`define XFER_NUM_ID       4
`define XFER_ID_W         2    // log2 of XFER_NUM_ID
`define XFER_DATA_W       16

// per-ID queue, also the depth of the checker shadow list
`define XFER_DEPTH        8
`define XFER_PTR_W        3    // log2 of XFER_DEPTH
`define XFER_CNT_W        4    // holds 0 to XFER_DEPTH

// checker limits
`define XFER_HANG_THRESH  16   // stalled cycles tolerated
`define XFER_HANG_W       8    // saturating stall counter width
`define XFER_OCC_LEVEL    12   // occ_high above this many words in flight
`define XFER_TOT_W        6    // holds 0 to XFER_NUM_ID * XFER_DEPTH
`define XFER_STAT_W       32   // per-ID input and output totals

// error word
`define XFER_ERR_W        5

`endif

// File: xfer_pkg.sv
`include "xfer_consts.svh"

package xfer_pkg;

  // stream identifier carried with every word
  typedef logic [`XFER_ID_W-1:0] xfer_id_t;

  // ==========================================================================
  // checker error word
  // raw bit 4 is hang, bit 0 is order_oldest
  // ==========================================================================
  typedef struct packed {
    logic hang;             // words stuck while the input stalls
    logic out_gt_in;        // more words left than entered
    logic count_underflow;  // word left an ID with nothing in flight
    logic order_exists;     // word left that never entered
    logic order_oldest;     // word left ahead of an older one
  } xfer_err_t;

  // named flags inside the checker, plain vector at the top port
  typedef union packed {
    xfer_err_t                f;
    logic [`XFER_ERR_W-1:0]   raw;
  } xfer_err_u;

endpackage

// File: id_queue_bank.sv
`timescale 1ns/1ps
`include "xfer_consts.svh"

module id_queue_bank
  import xfer_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst_n,

  // producer side
  input  logic                                   in_valid,
  input  xfer_id_t                               in_id,
  input  logic [`XFER_DATA_W-1:0]                in_data,
  output logic                                   in_taken,

  // arbiter side
  input  logic [`XFER_NUM_ID-1:0]                pop,
  output logic [`XFER_NUM_ID-1:0]                q_not_empty,
  output logic [`XFER_NUM_ID*`XFER_DATA_W-1:0]   head_data
);

  localparam logic [`XFER_CNT_W-1:0] FULL_CNT = `XFER_DEPTH;

  logic [`XFER_NUM_ID-1:0][`XFER_DEPTH-1:0][`XFER_DATA_W-1:0] mem;
  logic [`XFER_NUM_ID-1:0][`XFER_PTR_W-1:0]                   wr_ptr;
  logic [`XFER_NUM_ID-1:0][`XFER_PTR_W-1:0]                   rd_ptr;
  logic [`XFER_NUM_ID-1:0][`XFER_CNT_W-1:0]                   count;
  logic [`XFER_NUM_ID-1:0]                                    full;
  logic [`XFER_NUM_ID-1:0]                                    push;

  // ==========================================================================
  // queue status and push decode
  // ==========================================================================
  always_comb begin
    for (int i = 0; i < `XFER_NUM_ID; i++) begin
      full[i]        = (count[i] == FULL_CNT);
      q_not_empty[i] = (count[i] != '0);
    end
  end

  assign in_taken = !full[in_id];  // back-pressure only for the addressed ID

  always_comb begin
    push = '0;
    if (in_valid && in_taken) begin
      push[in_id] = 1'b1;
    end
  end

  // ==========================================================================
  // pointers and counts
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      for (int i = 0; i < `XFER_NUM_ID; i++) begin
        if (push[i]) begin
          wr_ptr[i] <= wr_ptr[i] + 1'b1;  // wraps at the power-of-two depth
        end
        if (pop[i]) begin
          rd_ptr[i] <= rd_ptr[i] + 1'b1;
        end
        case ({push[i], pop[i]})
          2'b10:   count[i] <= count[i] + 1'b1;
          2'b01:   count[i] <= count[i] - 1'b1;
          default: count[i] <= count[i];  // idle, or push and pop together
        endcase
      end
    end
  end

  // word storage
  always_ff @(posedge clk) begin
    if (|push) begin
      mem[in_id][wr_ptr[in_id]] <= in_data;
    end
  end

  // head of every queue, flattened with ID 0 in the low bits
  always_comb begin
    for (int i = 0; i < `XFER_NUM_ID; i++) begin
      head_data[i*`XFER_DATA_W +: `XFER_DATA_W] = mem[i][rd_ptr[i]];
    end
  end

  // ==========================================================================
  // assertions
  // ==========================================================================

  // the arbiter only pops queues that hold a word
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    (pop & ~q_not_empty) == '0)
    else $error("id_queue_bank: pop from empty queue, pop=%b", pop);

endmodule

// File: rr_egress_arb.sv
`timescale 1ns/1ps
`include "xfer_consts.svh"

module rr_egress_arb
  import xfer_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst_n,

  input  logic [`XFER_NUM_ID-1:0]                q_not_empty,
  input  logic [`XFER_NUM_ID*`XFER_DATA_W-1:0]   head_data,

  input  logic                                   out_taken,
  output logic                                   out_valid,
  output xfer_id_t                               out_id,
  output logic [`XFER_DATA_W-1:0]                out_data,

  output logic [`XFER_NUM_ID-1:0]                pop
);

  localparam xfer_id_t LAST_ID = xfer_id_t'(`XFER_NUM_ID - 1);

  xfer_id_t rr_ptr;    // highest priority ID for the next pick
  logic     hold_v;    // grant locked by a stalled transfer
  xfer_id_t hold_id;
  logic     sel_v;
  xfer_id_t sel_id;
  xfer_id_t grant_id;
  xfer_id_t next_ptr;
  logic     xfer;

  // ==========================================================================
  // round-robin pick, first non-empty ID at or after rr_ptr
  // ==========================================================================
  always_comb begin
    xfer_id_t idx;
    sel_v  = 1'b0;
    sel_id = rr_ptr;
    for (int k = `XFER_NUM_ID - 1; k >= 0; k--) begin  // lowest k wins
      idx = xfer_id_t'((int'(rr_ptr) + k) % `XFER_NUM_ID);
      if (q_not_empty[idx]) begin
        sel_v  = 1'b1;
        sel_id = idx;
      end
    end
  end

  assign grant_id  = hold_v ? hold_id : sel_id;
  assign out_valid = hold_v || sel_v;
  assign out_id    = grant_id;
  assign out_data  = head_data[grant_id*`XFER_DATA_W +: `XFER_DATA_W];
  assign xfer      = out_valid && out_taken;
  assign next_ptr  = (grant_id == LAST_ID) ? '0 : grant_id + 1'b1;

  always_comb begin
    pop = '0;
    if (xfer) begin
      pop[grant_id] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr  <= '0;
      hold_v  <= 1'b0;
      hold_id <= '0;
    end else begin
      hold_v  <= out_valid && !out_taken;  // freeze grant under back-pressure
      hold_id <= grant_id;
      if (xfer) begin
        rr_ptr <= next_ptr;
      end
    end
  end

  // a stalled word stays on the port until the consumer takes it
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_taken |=> out_valid && $stable(out_id) && $stable(out_data))
    else $error("rr_egress_arb: output changed during stall");

endmodule

// File: transfer_checker.sv
`timescale 1ns/1ps
`include "xfer_consts.svh"

module transfer_checker
  import xfer_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,

  // input port tap
  input  logic                        in_valid,
  input  logic                        in_taken,
  input  xfer_id_t                    in_id,
  input  logic [`XFER_DATA_W-1:0]     in_data,

  // output port tap
  input  logic                        out_valid,
  input  logic                        out_taken,
  input  xfer_id_t                    out_id,
  input  logic [`XFER_DATA_W-1:0]     out_data,

  // hang timer clear
  input  logic                        reset_count_v,
  input  xfer_id_t                    reset_count_id,

  output logic [`XFER_ERR_W-1:0]      err_flags,
  output logic                        occ_high
);

  localparam logic [`XFER_CNT_W-1:0]  FULL_CNT = `XFER_DEPTH;
  localparam logic [`XFER_HANG_W-1:0] HANG_LIM = `XFER_HANG_THRESH;
  localparam logic [`XFER_HANG_W-1:0] HANG_MAX = '1;
  localparam logic [`XFER_TOT_W-1:0]  OCC_LIM  = `XFER_OCC_LEVEL;

  logic [`XFER_NUM_ID-1:0][`XFER_DEPTH-1:0][`XFER_DATA_W-1:0] shadow;  // oldest at 0
  logic [`XFER_NUM_ID-1:0][`XFER_DEPTH-1:0][`XFER_DATA_W-1:0] shadow_nxt;
  logic [`XFER_NUM_ID-1:0][`XFER_CNT_W-1:0]                   id_cnt;  // words in flight
  logic [`XFER_NUM_ID-1:0][`XFER_CNT_W-1:0]                   id_cnt_nxt;
  logic [`XFER_NUM_ID-1:0][`XFER_STAT_W-1:0]                  in_cnt;
  logic [`XFER_NUM_ID-1:0][`XFER_STAT_W-1:0]                  in_cnt_nxt;
  logic [`XFER_NUM_ID-1:0][`XFER_STAT_W-1:0]                  out_cnt;
  logic [`XFER_NUM_ID-1:0][`XFER_STAT_W-1:0]                  out_cnt_nxt;
  logic [`XFER_NUM_ID-1:0][`XFER_HANG_W-1:0]                  hang_id;
  logic [`XFER_NUM_ID-1:0][`XFER_HANG_W-1:0]                  hang_id_nxt;
  logic [`XFER_TOT_W-1:0]                                     total;
  logic [`XFER_TOT_W-1:0]                                     total_nxt;
  logic [`XFER_HANG_W-1:0]                                    hang_tot;
  logic [`XFER_HANG_W-1:0]                                    hang_tot_nxt;

  logic                     in_acc;
  logic                     out_acc;
  logic                     in_stall;
  logic                     hit;
  logic                     hit_oldest;
  logic [`XFER_PTR_W-1:0]   hit_idx;
  xfer_err_u                err;

  assign in_acc   = in_valid && in_taken;
  assign out_acc  = out_valid && out_taken;
  assign in_stall = in_valid && !in_taken;

  always_comb begin
    shadow_nxt   = shadow;
    id_cnt_nxt   = id_cnt;
    in_cnt_nxt   = in_cnt;
    out_cnt_nxt  = out_cnt;
    total_nxt    = total;
    hang_tot_nxt = hang_tot;
    hang_id_nxt  = hang_id;
    hit          = 1'b0;
    hit_oldest   = 1'b0;
    hit_idx      = '0;
    err          = '0;

    // ========================================================================
    // accepted input, append to the shadow list of its ID
    // ========================================================================
    if (in_acc) begin
      if (id_cnt[in_id] != FULL_CNT) begin
        shadow_nxt[in_id][id_cnt[in_id][`XFER_PTR_W-1:0]] = in_data;
        id_cnt_nxt[in_id] = id_cnt_nxt[in_id] + 1'b1;
        total_nxt         = total_nxt + 1'b1;
      end
      in_cnt_nxt[in_id]  = in_cnt_nxt[in_id] + 1'b1;
      hang_tot_nxt       = '0;
      hang_id_nxt[in_id] = '0;
    end

    // ========================================================================
    // accepted output, find the word and close the gap behind it
    // ========================================================================
    if (out_acc) begin
      for (int d = 0; d < `XFER_DEPTH; d++) begin
        if (!hit && (d < int'(id_cnt_nxt[out_id])) && (shadow_nxt[out_id][d] == out_data)) begin
          hit        = 1'b1;
          hit_oldest = (d == 0);
          hit_idx    = d[`XFER_PTR_W-1:0];
        end
      end
      for (int d = 0; d < `XFER_DEPTH - 1; d++) begin
        if (hit && (d >= int'(hit_idx))) begin
          shadow_nxt[out_id][d] = shadow_nxt[out_id][d + 1];
        end
      end
      if (id_cnt_nxt[out_id] == '0) begin
        err.f.count_underflow = 1'b1;  // nothing of this ID in flight
      end else begin
        id_cnt_nxt[out_id] = id_cnt_nxt[out_id] - 1'b1;
        total_nxt          = total_nxt - 1'b1;
      end
      out_cnt_nxt[out_id] = out_cnt_nxt[out_id] + 1'b1;
      hang_tot_nxt        = '0;
      hang_id_nxt[out_id] = '0;
      err.f.order_exists  = !hit;
      err.f.order_oldest  = hit && !hit_oldest;
    end

    // external clear of the hang timers
    if (reset_count_v) begin
      hang_tot_nxt                = '0;
      hang_id_nxt[reset_count_id] = '0;
    end

    // ========================================================================
    // hang timers, count while words wait and the input is stalled
    // ========================================================================
    if (in_stall && (total != '0)) begin
      if (hang_tot_nxt != HANG_MAX) begin
        hang_tot_nxt = hang_tot_nxt + 1'b1;
      end
      if (hang_tot_nxt > HANG_LIM) begin
        err.f.hang = 1'b1;
      end
    end

    for (int i = 0; i < `XFER_NUM_ID; i++) begin
      if (in_stall && (id_cnt[i] != '0)) begin
        if (hang_id_nxt[i] != HANG_MAX) begin
          hang_id_nxt[i] = hang_id_nxt[i] + 1'b1;
        end
        if (hang_id_nxt[i] > HANG_LIM) begin
          err.f.hang = 1'b1;
        end
      end
      if (out_cnt_nxt[i] > in_cnt_nxt[i]) begin
        err.f.out_gt_in = 1'b1;
      end
    end
  end

  assign err_flags = err.raw;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_cnt   <= '0;
      in_cnt   <= '0;
      out_cnt  <= '0;
      total    <= '0;
      hang_tot <= '0;
      hang_id  <= '0;
      occ_high <= 1'b0;
    end else begin
      id_cnt   <= id_cnt_nxt;
      in_cnt   <= in_cnt_nxt;
      out_cnt  <= out_cnt_nxt;
      total    <= total_nxt;
      hang_tot <= hang_tot_nxt;
      hang_id  <= hang_id_nxt;
      occ_high <= (total_nxt > OCC_LIM);  // level of the count just written
    end
  end

  always_ff @(posedge clk) begin
    shadow <= shadow_nxt;
  end

  // queues and arbiter together deliver every word once and in order
  a_no_xfer_err: assert property (@(posedge clk) disable iff (!rst_n)
    !(err.f.order_exists || err.f.order_oldest || err.f.out_gt_in || err.f.count_underflow))
    else $error("transfer_checker: transfer error, flags=%b", err.raw);

endmodule

// File: xfer_subsys_top.sv
`timescale 1ns/1ps
`include "xfer_consts.svh"

module xfer_subsys_top
  import xfer_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,

  // input port
  input  logic                        in_valid,
  input  xfer_id_t                    in_id,
  input  logic [`XFER_DATA_W-1:0]     in_data,
  output logic                        in_taken,

  // output port
  output logic                        out_valid,
  output xfer_id_t                    out_id,
  output logic [`XFER_DATA_W-1:0]     out_data,
  input  logic                        out_taken,

  // checker
  input  logic                        reset_count_v,
  input  xfer_id_t                    reset_count_id,
  output logic [`XFER_ERR_W-1:0]      err_flags,
  output logic                        occ_high
);

  logic [`XFER_NUM_ID-1:0]                q_not_empty;
  logic [`XFER_NUM_ID*`XFER_DATA_W-1:0]   head_data;
  logic [`XFER_NUM_ID-1:0]                pop;

  // per-ID storage
  id_queue_bank queue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_id       (in_id),
    .in_data     (in_data),
    .in_taken    (in_taken),
    .pop         (pop),
    .q_not_empty (q_not_empty),
    .head_data   (head_data)
  );

  // single egress port
  rr_egress_arb arb_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .q_not_empty (q_not_empty),
    .head_data   (head_data),
    .out_taken   (out_taken),
    .out_valid   (out_valid),
    .out_id      (out_id),
    .out_data    (out_data),
    .pop         (pop)
  );

  // watches both ports
  transfer_checker chk_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_taken       (in_taken),
    .in_id          (in_id),
    .in_data        (in_data),
    .out_valid      (out_valid),
    .out_taken      (out_taken),
    .out_id         (out_id),
    .out_data       (out_data),
    .reset_count_v  (reset_count_v),
    .reset_count_id (reset_count_id),
    .err_flags      (err_flags),
    .occ_high       (occ_high)
  );

endmodule

// File: tb_xfer_subsys.sv
`timescale 1ns/1ps
`include "xfer_consts.svh"

module tb_xfer_subsys
  import xfer_pkg::*;
();

  localparam int CLK_NS      = 8;
  localparam int RST_CYC     = 4;
  localparam int RAND_CYC    = 1500;
  localparam int CASE_CYC    = 150;  // bound for one directed test and its drain
  localparam int MARGIN_CYC  = 200;
  localparam int WATCHDOG_NS = (RST_CYC + RAND_CYC + 5 * CASE_CYC + MARGIN_CYC) * CLK_NS;

  logic                     clk;
  logic                     rst_n;
  logic                     in_valid;
  xfer_id_t                 in_id;
  logic [`XFER_DATA_W-1:0]  in_data;
  logic                     in_taken;
  logic                     out_valid;
  xfer_id_t                 out_id;
  logic [`XFER_DATA_W-1:0]  out_data;
  logic                     out_taken;
  logic                     reset_count_v;
  xfer_id_t                 reset_count_id;
  logic [`XFER_ERR_W-1:0]   err_flags;
  logic                     occ_high;
  xfer_err_u                err_view;

  // reference model, stepped on the falling edge for the coming rising edge
  logic [`XFER_DATA_W-1:0]  model_q [`XFER_NUM_ID][$];
  xfer_id_t                 model_rr;
  logic                     model_hold_v;
  xfer_id_t                 model_hold_id;
  logic                     exp_valid;
  xfer_id_t                 exp_id;
  logic [`XFER_DATA_W-1:0]  exp_data;
  logic                     exp_in_taken;
  logic                     in_fire;
  logic                     out_fire;
  int                       cur_total;  // words in flight after the last edge
  int                       stall_cnt;
  logic                     hang_watch;

  logic [31:0]              lcg_state;
  int                       err_count;
  int                       err_mark;
  int                       n_tests;
  int                       n_failed;

  xfer_subsys_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_id          (in_id),
    .in_data        (in_data),
    .in_taken       (in_taken),
    .out_valid      (out_valid),
    .out_id         (out_id),
    .out_data       (out_data),
    .out_taken      (out_taken),
    .reset_count_v  (reset_count_v),
    .reset_count_id (reset_count_id),
    .err_flags      (err_flags),
    .occ_high       (occ_high)
  );

  assign err_view = err_flags;

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`XFER_DATA_W-1:0] rand_word();
    logic [31:0] r;
    r = next_rand();
    return r[31:16];  // upper bits of an LCG are the better ones
  endfunction

  // round robin, the first ID holding words at or after start
  function automatic xfer_id_t first_ready(input xfer_id_t start);
    logic     found;
    xfer_id_t cand;
    found = 1'b0;
    first_ready = start;
    for (int k = 0; k < `XFER_NUM_ID; k++) begin
      cand = xfer_id_t'((int'(start) + k) % `XFER_NUM_ID);
      if (!found && model_q[cand].size() != 0) begin
        found = 1'b1;
        first_ready = cand;
      end
    end
  endfunction

  function automatic void log_failure(input string msg);
    err_count++;
    $display("%s", msg);
  endfunction

  // ==========================================================================
  // model step
  // ==========================================================================
  always @(negedge clk) begin
    xfer_id_t grant;
    int       total;
    if (!rst_n) begin
      for (int i = 0; i < `XFER_NUM_ID; i++) begin
        model_q[i].delete();
      end
      model_rr      = '0;
      model_hold_v  = 1'b0;
      model_hold_id = '0;
      exp_valid     = 1'b0;
      exp_id        = '0;
      exp_data      = '0;
      exp_in_taken  = 1'b1;
      in_fire       = 1'b0;
      out_fire      = 1'b0;
      cur_total     = 0;
      stall_cnt     = 0;
    end else begin
      total = 0;
      for (int i = 0; i < `XFER_NUM_ID; i++) begin
        total += model_q[i].size();
      end
      cur_total    = total;
      grant        = model_hold_v ? model_hold_id : first_ready(model_rr);
      exp_valid    = model_hold_v || (total != 0);
      exp_id       = grant;
      exp_data     = (model_q[grant].size() != 0) ? model_q[grant][0] : '0;
      exp_in_taken = model_q[in_id].size() < `XFER_DEPTH;
      in_fire      = in_valid && exp_in_taken;
      out_fire     = exp_valid && out_taken;

      // stall timer, any transfer or a clear pulse restarts it
      if (in_fire || out_fire || reset_count_v) begin
        stall_cnt = 0;
      end
      if (in_valid && !exp_in_taken && total != 0) begin
        stall_cnt++;
      end

      model_hold_v  = exp_valid && !out_taken;
      model_hold_id = grant;
      if (out_fire) begin
        void'(model_q[grant].pop_front());
        model_rr = xfer_id_t'((int'(grant) + 1) % `XFER_NUM_ID);  // just past the one served
      end
      if (in_fire) begin
        model_q[in_id].push_back(in_data);
      end
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================
  a_out_valid: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == exp_valid)
    else log_failure($sformatf("** Error: out_valid got %h expected %h",
                               $sampled(out_valid), exp_valid));

  a_out_id: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> out_id == exp_id)
    else log_failure($sformatf("** Error: out_id got %h expected %h",
                               $sampled(out_id), exp_id));

  a_out_data: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_taken |-> out_data == exp_data)
    else log_failure($sformatf("** Error: out_data got %h expected %h",
                               $sampled(out_data), exp_data));

  a_in_taken: assert property (@(posedge clk) disable iff (!rst_n)
    in_taken == exp_in_taken)
    else log_failure($sformatf("** Error: in_taken got %h expected %h for id %h",
                               $sampled(in_taken), exp_in_taken, $sampled(in_id)));

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_taken |=> $stable(out_id) && $stable(out_data))
    else log_failure("output word changed while the consumer stalled");

  // order and count bits, hang may rise on its own
  a_order_clear: assert property (@(posedge clk) disable iff (!rst_n)
    err_flags[3:0] == 4'h0)
    else log_failure($sformatf("** Error: err_flags got %h expected %h",
                               $sampled(err_flags), {$sampled(err_flags[4]), 4'h0}));

  a_occ: assert property (@(posedge clk) disable iff (!rst_n)
    occ_high == (cur_total > `XFER_OCC_LEVEL))
    else log_failure($sformatf("** Error: occ_high got %h expected %h",
                               $sampled(occ_high), cur_total > `XFER_OCC_LEVEL));

  a_hang_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    hang_watch && stall_cnt <= `XFER_HANG_THRESH |-> !err_view.f.hang)
    else log_failure($sformatf("** Error: err_flags.hang got %h expected %h",
                               $sampled(err_flags[4]), 1'b0));

  a_hang_rise: assert property (@(posedge clk) disable iff (!rst_n)
    hang_watch && stall_cnt >= `XFER_HANG_THRESH + 2 |-> err_view.f.hang)
    else log_failure($sformatf("** Error: err_flags.hang got %h expected %h",
                               $sampled(err_flags[4]), 1'b1));

  // ==========================================================================
  // stimulus
  // ==========================================================================
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic push_word(input xfer_id_t id, input logic [`XFER_DATA_W-1:0] data);
    in_valid = 1'b1;
    in_id    = id;
    in_data  = data;
    do begin
      @(posedge clk);
      #1;
    end while (!in_fire);
    in_valid = 1'b0;
  endtask

  task automatic drain_all();
    out_taken = 1'b1;
    while (in_valid) begin  // let a pending word go in first
      @(posedge clk);
      #1;
      if (in_fire) begin
        in_valid = 1'b0;
      end
    end
    while (out_valid) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report_test(input string name);
    n_tests++;
    if (err_count == err_mark) begin
      $display("test %-16s pass", name);
    end else begin
      n_failed++;
      $display("test %-16s fail, %0d errors", name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  task automatic run_random_traffic();
    logic [31:0] r;
    for (int c = 0; c < RAND_CYC; c++) begin
      r = next_rand();
      if (!in_valid || in_fire) begin  // a word stays on the port until taken
        in_valid = r[31] | r[30];
        in_id    = r[29:28];
        in_data  = r[27:12];
      end
      out_taken = r[11] | ((c >= RAND_CYC / 2) && r[10]);  // faster drain later on
      idle_cycles(1);
    end
    drain_all();
  endtask

  task automatic run_fairness();
    out_taken = 1'b0;
    for (int n = 0; n < 2 * `XFER_NUM_ID; n++) begin
      push_word(xfer_id_t'(`XFER_NUM_ID - 1 - n % `XFER_NUM_ID), rand_word());
    end
    drain_all();  // all four busy, grant walks the rotation
  endtask

  task automatic run_backpressure();
    out_taken = 1'b0;
    for (int n = 0; n < `XFER_DEPTH; n++) begin
      push_word(2'd2, rand_word());
    end
    in_id = 2'd2;  // full
    idle_cycles(3);
    in_id = 2'd0;  // empty
    idle_cycles(3);
    drain_all();
  endtask

  task automatic run_occupancy();
    out_taken = 1'b0;
    for (int n = 0; n < `XFER_OCC_LEVEL + 4; n++) begin
      push_word(xfer_id_t'(n % `XFER_NUM_ID), rand_word());
    end
    idle_cycles(3);
    drain_all();
  endtask

  task automatic run_hang();
    out_taken = 1'b0;
    for (int n = 0; n < `XFER_DEPTH; n++) begin
      push_word(2'd1, rand_word());
    end
    in_valid   = 1'b1;  // blocked on the full queue from here on
    in_id      = 2'd1;
    in_data    = rand_word();
    hang_watch = 1'b1;
    idle_cycles(`XFER_HANG_THRESH + 4);
    reset_count_v  = 1'b1;
    reset_count_id = 2'd1;
    idle_cycles(1);
    reset_count_v  = 1'b0;
    idle_cycles(3);
    hang_watch = 1'b0;
    in_valid   = 1'b0;  // word withdrawn
    drain_all();
  endtask

  initial begin
    lcg_state      = 32'h55f5_df0f;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    in_id          = '0;
    in_data        = '0;
    out_taken      = 1'b0;
    reset_count_v  = 1'b0;
    reset_count_id = '0;
    hang_watch     = 1'b0;
    err_count      = 0;
    err_mark       = 0;
    n_tests        = 0;
    n_failed       = 0;
    repeat (RST_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle_cycles(2);

    run_random_traffic();
    report_test("random traffic");
    run_fairness();
    report_test("fairness");
    run_backpressure();
    report_test("back-pressure");
    run_occupancy();
    report_test("occupancy");
    run_hang();
    report_test("hang detect");

    $display("tests run %0d, tests failed %0d, check errors %0d", n_tests, n_failed, err_count);
    if (n_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
xfer_pkg.sv
id_queue_bank.sv
rr_egress_arb.sv
transfer_checker.sv
xfer_subsys_top.sv
tb_xfer_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_xfer_subsys \
  -f sources.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
